// ==== sources.f ====
design/boundary_pkg.sv
design/boundary_if.sv
design/pipe_reg.sv
design/boundary_in.sv
design/slot_engine.sv
design/boundary_out.sv
design/core_region.sv
bench/core_region_tb.sv

// ==== Bender.yml ====
package:
  name: core_region

sources:
  - design/boundary_pkg.sv
  - design/boundary_if.sv
  - design/pipe_reg.sv
  - design/boundary_in.sv
  - design/slot_engine.sv
  - design/boundary_out.sv
  - design/core_region.sv
  - target: simulation
    files:
      - bench/core_region_tb.sv

// ==== bench/core_region_tb.sv ====
`timescale 1ns/1ps

module core_region_tb;

  typedef enum logic [1:0] {
    OP_HOST,
    OP_DESC,
    OP_POKE,
    OP_CORE_RST
  } op_e;

  // Status expectations keep the address in bits 33:32
  typedef struct {
    string       name;
    op_e         op;
    logic [63:0] word;
    logic [63:0] exp;
  } test_t;

  localparam int n_tests = 17;

  logic        clk;
  logic        rst_n;
  logic        core_rst;
  logic        poke_int;
  logic        poke_int_ack;
  logic [63:0] in_desc;
  logic        in_desc_valid;
  logic        in_desc_taken;
  logic [63:0] out_desc;
  logic [63:0] out_desc_dram_addr;
  logic        out_desc_valid;
  logic        out_desc_ready;
  logic [31:0] host_status_data;
  logic [1:0]  host_status_addr;
  logic        host_status_valid;
  logic        host_status_ready;
  logic [31:0] core_status_data;
  logic [1:0]  core_status_addr;
  logic        core_status_valid;
  logic        core_status_ready;

  test_t        tests [n_tests];
  logic [127:0] exp_desc_q [$];
  string        desc_name_q [$];
  logic [33:0]  exp_stat_q [$];
  string        stat_name_q [$];
  logic         hold_desc;
  int           ack_count;

  core_region #(
    .REG_STAGES (1),
    .SLOT_SHIFT (12)
  ) dut_i (
    .clk(clk), .rst_n(rst_n), .core_rst(core_rst),
    .poke_int(poke_int), .poke_int_ack(poke_int_ack),
    .in_desc(in_desc), .in_desc_valid(in_desc_valid), .in_desc_taken(in_desc_taken),
    .out_desc(out_desc), .out_desc_dram_addr(out_desc_dram_addr),
    .out_desc_valid(out_desc_valid), .out_desc_ready(out_desc_ready),
    .host_status_data(host_status_data), .host_status_addr(host_status_addr),
    .host_status_valid(host_status_valid), .host_status_ready(host_status_ready),
    .core_status_data(core_status_data), .core_status_addr(core_status_addr),
    .core_status_valid(core_status_valid), .core_status_ready(core_status_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure handling
  //////////////////////////////////////////////////////////////////////
  task automatic stop_failed();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic value_error(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    stop_failed();
  endtask

  task automatic plain_error(input string why);
    $display("[ERROR] %s", why);
    stop_failed();
  endtask

  // Watchdog, 200 cycles per table entry
  initial begin
    repeat (n_tests * 200) @(posedge clk);
    plain_error("timeout, the test table did not finish within the cycle limit");
  end

  //////////////////////////////////////////////////////////////////////
  // Output monitor and scoreboard
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    logic [127:0] e_desc;
    logic [33:0]  e_stat;
    string        name;
    if (rst_n && out_desc_valid && out_desc_ready) begin
      assert (exp_desc_q.size() != 0) begin
        e_desc = exp_desc_q.pop_front();
        name   = desc_name_q.pop_front();
        assert (out_desc === e_desc[63:0])
          else value_error(name, e_desc[63:0], out_desc);
        assert (out_desc_dram_addr === e_desc[127:64])
          else value_error(name, e_desc[127:64], out_desc_dram_addr);
      end else begin
        plain_error("an outbound descriptor arrived while none was expected");
      end
    end
    if (rst_n && core_status_valid && core_status_ready) begin
      assert (exp_stat_q.size() != 0) begin
        e_stat = exp_stat_q.pop_front();
        name   = stat_name_q.pop_front();
        assert ({core_status_addr, core_status_data} === e_stat)
          else value_error(name, 64'(e_stat), 64'({core_status_addr, core_status_data}));
      end else begin
        plain_error("a core status word arrived while none was expected");
      end
    end
    if (rst_n && poke_int_ack) begin
      ack_count <= ack_count + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////
  task automatic wait_drain();
    while (exp_desc_q.size() != 0 || exp_stat_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic send_desc(input logic [63:0] word);
    in_desc       <= word;
    in_desc_valid <= 1'b1;
    @(posedge clk);
    while (!in_desc_taken) @(posedge clk);
    in_desc_valid <= 1'b0;
  endtask

  task automatic write_host(input logic [63:0] word);
    host_status_addr  <= word[33:32];
    host_status_data  <= word[31:0];
    host_status_valid <= 1'b1;
    @(posedge clk);
    while (!host_status_ready) @(posedge clk);
    host_status_valid <= 1'b0;
    // Let the write reach the engine before the next descriptor
    repeat (4) @(posedge clk);
  endtask

  task automatic poke_and_wait();
    int acks_before;
    acks_before = ack_count;
    poke_int <= 1'b1;
    @(posedge clk);
    while (ack_count == acks_before) @(posedge clk);
    poke_int <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  // Park one packet at the output, then flush it with core_rst
  task automatic flush_with_core_rst(input logic [63:0] word);
    hold_desc = 1'b1;
    send_desc(word);
    while (!out_desc_valid) @(posedge clk);
    core_rst <= 1'b1;
    repeat (3) @(posedge clk);
    assert (!out_desc_valid)
      else plain_error("out_desc_valid stayed high while core_rst was held");
    core_rst <= 1'b0;
    repeat (3) @(posedge clk);
    hold_desc = 1'b0;
  endtask

  task automatic load_table();
    tests[0]  = '{"base_write",          OP_HOST,     64'h0000_0000_8000_0000, 64'h0};
    tests[1]  = '{"pkt_slot3",           OP_DESC,     64'h0003_0040_0000_0100,
                  64'h0000_0000_8000_3100};
    tests[2]  = '{"pkt_addr_carry",      OP_DESC,     64'h00ff_05dc_ffff_fff0,
                  64'h0000_0001_800f_eff0};
    tests[3]  = '{"msg_value",           OP_DESC,     64'h4000_0000_cafe_0001,
                  64'h0000_0003_cafe_0001};
    tests[4]  = '{"msg_reserved_kind",   OP_DESC,     64'hc000_0012_0bad_f00d,
                  64'h0000_0003_0bad_f00d};
    tests[5]  = '{"pkt_rsvd_bits",       OP_DESC,     64'h3f00_0010_0000_0004,
                  64'h0000_0000_8000_0004};
    tests[6]  = '{"poke_after_3",        OP_POKE,     64'h0, 64'h0000_0002_0000_0003};
    tests[7]  = '{"clear_count",         OP_HOST,     64'h0000_0001_0000_0000, 64'h0};
    tests[8]  = '{"poke_after_clear",    OP_POKE,     64'h0, 64'h0000_0002_0000_0000};
    tests[9]  = '{"base_write_2",        OP_HOST,     64'h0000_0000_0010_0000, 64'h0};
    tests[10] = '{"pkt_burst_a",         OP_DESC,     64'h0001_0100_0000_0020,
                  64'h0000_0000_0010_1020};
    tests[11] = '{"msg_burst",           OP_DESC,     64'h4000_0000_1234_5678,
                  64'h0000_0003_1234_5678};
    tests[12] = '{"pkt_burst_b",         OP_DESC,     64'h0010_0200_0000_0abc,
                  64'h0000_0000_0011_0abc};
    tests[13] = '{"pkt_burst_c",         OP_DESC,     64'h0080_0001_0001_0000,
                  64'h0000_0000_0019_0000};
    tests[14] = '{"core_rst_flush",      OP_CORE_RST, 64'h0002_0008_0000_0000, 64'h0};
    tests[15] = '{"pkt_after_core_rst",  OP_DESC,     64'h0004_0020_0000_0008,
                  64'h0000_0000_0010_4008};
    // The flushed packet was already counted by the engine
    tests[16] = '{"poke_after_core_rst", OP_POKE,     64'h0, 64'h0000_0002_0000_0005};
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    boundary_pkg::desc_u d;
    int                  n_pokes;
    int                  seed;
    seed = $urandom(32'hd175);
    n_pokes   = 0;
    ack_count = 0;
    hold_desc = 1'b0;
    rst_n             <= 1'b0;
    core_rst          <= 1'b0;
    poke_int          <= 1'b0;
    in_desc           <= '0;
    in_desc_valid     <= 1'b0;
    host_status_data  <= '0;
    host_status_addr  <= '0;
    host_status_valid <= 1'b0;
    out_desc_ready    <= 1'b0;
    core_status_ready <= 1'b0;
    load_table();

    // Random stalls on both outputs
    fork
      forever begin
        @(posedge clk);
        out_desc_ready    <= !hold_desc && ($urandom % 4 != 0);
        core_status_ready <= ($urandom % 4 != 0);
      end
    join_none

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (in_desc_taken && host_status_ready && !out_desc_valid
            && !core_status_valid && !poke_int_ack)
      else plain_error("outputs are not in their reset state after reset");

    for (int i = 0; i < n_tests; i++) begin
      repeat ($urandom % 4) @(posedge clk);
      d = tests[i].word;
      case (tests[i].op)
        OP_HOST: begin
          wait_drain();
          write_host(tests[i].word);
        end
        OP_DESC: begin
          if (d.pkt.kind == boundary_pkg::DESC_PKT) begin
            exp_desc_q.push_back({tests[i].exp, tests[i].word});
            desc_name_q.push_back(tests[i].name);
          end else begin
            exp_stat_q.push_back(tests[i].exp[33:0]);
            stat_name_q.push_back(tests[i].name);
          end
          send_desc(tests[i].word);
        end
        OP_POKE: begin
          wait_drain();
          exp_stat_q.push_back(tests[i].exp[33:0]);
          stat_name_q.push_back(tests[i].name);
          poke_and_wait();
          n_pokes++;
        end
        default: begin
          wait_drain();
          flush_with_core_rst(tests[i].word);
        end
      endcase
    end

    wait_drain();
    repeat (8) @(posedge clk);
    assert (ack_count == n_pokes)
      else value_error("poke_ack_count", 64'(n_pokes), 64'(ack_count));
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== design/core_region.sv ====
`timescale 1ns/1ps

module core_region #(
  parameter int REG_STAGES = 1,
  parameter int SLOT_SHIFT = 12
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 core_rst,

  input  logic                                 poke_int,
  output logic                                 poke_int_ack,

  input  logic [boundary_pkg::desc_w-1:0]      in_desc,
  input  logic                                 in_desc_valid,
  output logic                                 in_desc_taken,

  output logic [boundary_pkg::desc_w-1:0]      out_desc,
  output logic [boundary_pkg::desc_w-1:0]      out_desc_dram_addr,
  output logic                                 out_desc_valid,
  input  logic                                 out_desc_ready,

  input  logic [boundary_pkg::stat_data_w-1:0] host_status_data,
  input  logic [boundary_pkg::stat_addr_w-1:0] host_status_addr,
  input  logic                                 host_status_valid,
  output logic                                 host_status_ready,

  output logic [boundary_pkg::stat_data_w-1:0] core_status_data,
  output logic [boundary_pkg::stat_addr_w-1:0] core_status_addr,
  output logic                                 core_status_valid,
  input  logic                                 core_status_ready
);

  logic [boundary_pkg::desc_w-1:0] desc_data;
  logic                            desc_valid;
  logic                            desc_taken;
  logic                            core_rst_r;
  logic                            poke_int_r;
  logic                            poke_ack;

  status_if   host_stat ();
  status_if   core_stat ();
  desc_out_if desc_out ();

  boundary_in #(.REG_STAGES(REG_STAGES)) in_inst (
    .clk(clk), .rst_n(rst_n),
    .in_desc(in_desc), .in_desc_valid(in_desc_valid), .in_desc_taken(in_desc_taken),
    .host_status_data(host_status_data), .host_status_addr(host_status_addr),
    .host_status_valid(host_status_valid), .host_status_ready(host_status_ready),
    .core_rst(core_rst), .poke_int(poke_int),
    .desc_data(desc_data), .desc_valid(desc_valid), .desc_taken(desc_taken),
    .host_stat(host_stat.src),
    .core_rst_r(core_rst_r), .poke_int_r(poke_int_r)
  );

  slot_engine #(.SLOT_SHIFT(SLOT_SHIFT)) engine_inst (
    .clk(clk), .rst_n(rst_n), .core_rst(core_rst_r),
    .desc_data(desc_data), .desc_valid(desc_valid), .desc_taken(desc_taken),
    .host_stat(host_stat.dst),
    .poke_int(poke_int_r), .poke_ack(poke_ack),
    .desc_out(desc_out.src), .core_stat(core_stat.src)
  );

  boundary_out #(.REG_STAGES(REG_STAGES)) out_inst (
    .clk(clk), .rst_n(rst_n), .core_rst(core_rst_r),
    .desc_out(desc_out.dst), .core_stat(core_stat.dst), .poke_ack(poke_ack),
    .out_desc(out_desc), .out_desc_dram_addr(out_desc_dram_addr),
    .out_desc_valid(out_desc_valid), .out_desc_ready(out_desc_ready),
    .core_status_data(core_status_data), .core_status_addr(core_status_addr),
    .core_status_valid(core_status_valid), .core_status_ready(core_status_ready),
    .poke_int_ack(poke_int_ack)
  );

endmodule

// ==== design/boundary_out.sv ====
`timescale 1ns/1ps

module boundary_out #(
  parameter int REG_STAGES = 1
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 core_rst,

  desc_out_if.dst                              desc_out,
  status_if.dst                                core_stat,
  input  logic                                 poke_ack,

  output logic [boundary_pkg::desc_w-1:0]      out_desc,
  output logic [boundary_pkg::desc_w-1:0]      out_desc_dram_addr,
  output logic                                 out_desc_valid,
  input  logic                                 out_desc_ready,

  output logic [boundary_pkg::stat_data_w-1:0] core_status_data,
  output logic [boundary_pkg::stat_addr_w-1:0] core_status_addr,
  output logic                                 core_status_valid,
  input  logic                                 core_status_ready,

  output logic                                 poke_int_ack
);

  // Descriptor and address travel as one word
  pipe_reg #(
    .WIDTH      (2 * boundary_pkg::desc_w),
    .REG_STAGES (REG_STAGES)
  ) out_desc_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (core_rst),
    .s_data  ({desc_out.dram_addr, desc_out.desc}),
    .s_valid (desc_out.valid),
    .s_ready (desc_out.ready),
    .m_data  ({out_desc_dram_addr, out_desc}),
    .m_valid (out_desc_valid),
    .m_ready (out_desc_ready)
  );

  pipe_reg #(
    .WIDTH      (boundary_pkg::stat_addr_w + boundary_pkg::stat_data_w),
    .REG_STAGES (REG_STAGES)
  ) core_status_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (1'b0),
    .s_data  ({core_stat.addr, core_stat.data}),
    .s_valid (core_stat.valid),
    .s_ready (core_stat.ready),
    .m_data  ({core_status_addr, core_status_data}),
    .m_valid (core_status_valid),
    .m_ready (core_status_ready)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      poke_int_ack <= 1'b0;
    end else begin
      poke_int_ack <= poke_ack;
    end
  end

endmodule

// ==== design/slot_engine.sv ====
`timescale 1ns/1ps

module slot_engine #(
  parameter int SLOT_SHIFT = 12
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            core_rst,

  input  logic [boundary_pkg::desc_w-1:0] desc_data,
  input  logic                            desc_valid,
  output logic                            desc_taken,

  status_if.dst                           host_stat,

  input  logic                            poke_int,
  output logic                            poke_ack,

  desc_out_if.src                         desc_out,
  status_if.src                           core_stat
);

  localparam int aw = boundary_pkg::desc_w;
  localparam int sw = boundary_pkg::stat_data_w;

  boundary_pkg::desc_u desc;

  logic          is_pkt;
  logic          od_free;
  logic          cs_free;
  logic          pkt_fire;
  logic          msg_fire;
  logic          poke_req;
  logic          cs_is_poke;
  logic          poke_done;
  logic          base_wr;
  logic          clr_wr;
  logic [aw-1:0] pkt_addr;
  logic [sw-1:0] dram_base;
  logic [sw-1:0] pkt_count;

  //////////////////////////////////////////////////////////////////////
  // Descriptor decode
  //////////////////////////////////////////////////////////////////////
  assign desc   = desc_data;
  assign is_pkt = (desc.pkt.kind == boundary_pkg::DESC_PKT);

  assign od_free = !desc_out.valid || desc_out.ready;
  assign cs_free = !core_stat.valid || core_stat.ready;

  // Stall only on the result register this word needs
  assign desc_taken = is_pkt ? od_free : cs_free;
  assign pkt_fire   = desc_valid && desc_taken && is_pkt && !core_rst;
  assign msg_fire   = desc_valid && desc_taken && !is_pkt;

  assign pkt_addr = aw'(dram_base) + (aw'(desc.pkt.slot) << SLOT_SHIFT)
                  + aw'(desc.pkt.offset);

  //////////////////////////////////////////////////////////////////////
  // Host writes, always accepted
  //////////////////////////////////////////////////////////////////////
  assign host_stat.ready = 1'b1;
  assign base_wr = host_stat.valid && host_stat.addr == boundary_pkg::STAT_DRAM_BASE;
  assign clr_wr  = host_stat.valid && host_stat.addr == boundary_pkg::STAT_CLR_COUNT;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dram_base <= '0;
      pkt_count <= '0;
    end else begin
      if (base_wr) begin
        dram_base <= host_stat.data;
      end
      // A packet taken in the clear cycle still counts
      if (clr_wr || pkt_fire) begin
        pkt_count <= (clr_wr ? '0 : pkt_count) + sw'(pkt_fire);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outbound descriptor register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desc_out.valid <= 1'b0;
    end else if (core_rst) begin
      desc_out.valid <= 1'b0;
    end else if (od_free) begin
      desc_out.valid <= pkt_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (pkt_fire) begin
      desc_out.desc      <= desc_data;
      desc_out.dram_addr <= pkt_addr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Core status register, message first, then poke
  //////////////////////////////////////////////////////////////////////
  assign poke_req = poke_int && !poke_done && !(core_stat.valid && cs_is_poke);
  assign poke_ack = core_stat.valid && core_stat.ready && cs_is_poke;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_stat.valid <= 1'b0;
      cs_is_poke      <= 1'b0;
    end else if (cs_free) begin
      core_stat.valid <= msg_fire || poke_req;
      cs_is_poke      <= !msg_fire && poke_req;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_free) begin
      core_stat.addr <= msg_fire ? boundary_pkg::STAT_MSG : boundary_pkg::STAT_PKT_COUNT;
      core_stat.data <= msg_fire ? desc.msg.value : pkt_count;
    end
  end

  // Hold off a second answer until the host drops poke_int
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      poke_done <= 1'b0;
    end else if (!poke_int) begin
      poke_done <= 1'b0;
    end else if (poke_ack) begin
      poke_done <= 1'b1;
    end
  end

  a_desc_out_hold: assert property (@(posedge clk) disable iff (!rst_n || core_rst)
    desc_out.valid && !desc_out.ready |=>
      desc_out.valid && $stable(desc_out.desc) && $stable(desc_out.dram_addr));

  a_core_stat_hold: assert property (@(posedge clk) disable iff (!rst_n)
    core_stat.valid && !core_stat.ready |=>
      core_stat.valid && $stable(core_stat.data) && $stable(core_stat.addr));

  // Host must keep poke_int up until it sees the ack
  a_ack_needs_poke: assert property (@(posedge clk) disable iff (!rst_n)
    poke_ack |-> poke_int);

endmodule

// ==== design/boundary_in.sv ====
`timescale 1ns/1ps

module boundary_in #(
  parameter int REG_STAGES = 1
) (
  input  logic                                 clk,
  input  logic                                 rst_n,

  input  logic [boundary_pkg::desc_w-1:0]      in_desc,
  input  logic                                 in_desc_valid,
  output logic                                 in_desc_taken,

  input  logic [boundary_pkg::stat_data_w-1:0] host_status_data,
  input  logic [boundary_pkg::stat_addr_w-1:0] host_status_addr,
  input  logic                                 host_status_valid,
  output logic                                 host_status_ready,

  input  logic                                 core_rst,
  input  logic                                 poke_int,

  output logic [boundary_pkg::desc_w-1:0]      desc_data,
  output logic                                 desc_valid,
  input  logic                                 desc_taken,

  status_if.src                                host_stat,

  output logic                                 core_rst_r,
  output logic                                 poke_int_r
);

  // Level inputs cross on a single flop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rst_r <= 1'b0;
      poke_int_r <= 1'b0;
    end else begin
      core_rst_r <= core_rst;
      poke_int_r <= poke_int;
    end
  end

  // Descriptor path also flushes on core reset
  pipe_reg #(
    .WIDTH      (boundary_pkg::desc_w),
    .REG_STAGES (REG_STAGES)
  ) desc_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (core_rst_r),
    .s_data  (in_desc),
    .s_valid (in_desc_valid),
    .s_ready (in_desc_taken),
    .m_data  (desc_data),
    .m_valid (desc_valid),
    .m_ready (desc_taken)
  );

  pipe_reg #(
    .WIDTH      (boundary_pkg::stat_addr_w + boundary_pkg::stat_data_w),
    .REG_STAGES (REG_STAGES)
  ) host_status_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (1'b0),
    .s_data  ({host_status_addr, host_status_data}),
    .s_valid (host_status_valid),
    .s_ready (host_status_ready),
    .m_data  ({host_stat.addr, host_stat.data}),
    .m_valid (host_stat.valid),
    .m_ready (host_stat.ready)
  );

endmodule

// ==== design/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
  parameter int WIDTH      = 64,
  parameter int REG_STAGES = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clear,

  input  logic [WIDTH-1:0] s_data,
  input  logic             s_valid,
  output logic             s_ready,

  output logic [WIDTH-1:0] m_data,
  output logic             m_valid,
  input  logic             m_ready
);

  // Index i is the input of stage i, index REG_STAGES the output
  logic [REG_STAGES:0][WIDTH-1:0] st_data;
  logic [REG_STAGES:0]            st_valid;
  logic [REG_STAGES:0]            st_ready;

  assign st_data[0]           = s_data;
  assign st_valid[0]          = s_valid;
  assign s_ready              = st_ready[0];

  assign m_data               = st_data[REG_STAGES];
  assign m_valid              = st_valid[REG_STAGES];
  assign st_ready[REG_STAGES] = m_ready;

  for (genvar i = 0; i < REG_STAGES; i++) begin : g_stage
    logic [WIDTH-1:0] main_data;
    logic [WIDTH-1:0] skid_data;
    logic             main_valid;
    logic             skid_valid;
    logic             out_free;

    // Ready comes from the skid flop only, never from downstream
    assign st_ready[i]   = !skid_valid;
    assign out_free      = !main_valid || st_ready[i+1];
    assign st_data[i+1]  = main_data;
    assign st_valid[i+1] = main_valid;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        main_valid <= 1'b0;
        skid_valid <= 1'b0;
      end else if (clear) begin
        main_valid <= 1'b0;
        skid_valid <= 1'b0;
      end else if (out_free) begin
        main_valid <= skid_valid || st_valid[i];
        skid_valid <= 1'b0;
      end else if (st_valid[i] && !skid_valid) begin
        skid_valid <= 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (out_free) begin
        main_data <= skid_valid ? skid_data : st_data[i];
      end
      // Catch the word that arrives while the output is stalled
      if (!out_free && !skid_valid) begin
        skid_data <= st_data[i];
      end
    end
  end

  a_m_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready && !clear |=> m_valid && $stable(m_data));

endmodule

// ==== design/boundary_if.sv ====
`timescale 1ns/1ps

// Status word channel, used for host writes and core reports
interface status_if;
  logic [boundary_pkg::stat_data_w-1:0] data;
  logic [boundary_pkg::stat_addr_w-1:0] addr;
  logic                                 valid;
  logic                                 ready;

  modport src (
    output data,
    output addr,
    output valid,
    input  ready
  );

  modport dst (
    input  data,
    input  addr,
    input  valid,
    output ready
  );
endinterface

// Outbound descriptor with its DRAM address
interface desc_out_if;
  logic [boundary_pkg::desc_w-1:0] desc;
  logic [boundary_pkg::desc_w-1:0] dram_addr;
  logic                            valid;
  logic                            ready;

  modport src (
    output desc,
    output dram_addr,
    output valid,
    input  ready
  );

  modport dst (
    input  desc,
    input  dram_addr,
    input  valid,
    output ready
  );
endinterface

// ==== design/boundary_pkg.sv ====
package boundary_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths shared across the boundary
  //////////////////////////////////////////////////////////////////////
  localparam int desc_w      = 64;
  localparam int stat_addr_w = 2;
  localparam int stat_data_w = 32;

  // Host writes
  localparam logic [stat_addr_w-1:0] STAT_DRAM_BASE = 2'd0;
  localparam logic [stat_addr_w-1:0] STAT_CLR_COUNT = 2'd1;
  // Core reports
  localparam logic [stat_addr_w-1:0] STAT_PKT_COUNT = 2'd2;
  localparam logic [stat_addr_w-1:0] STAT_MSG       = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Descriptor word
  //////////////////////////////////////////////////////////////////////
  // Codes 2 and 3 are reserved and handled as messages
  typedef enum logic [1:0] {
    DESC_PKT = 2'd0,
    DESC_MSG = 2'd1
  } desc_kind_e;

  typedef struct packed {
    desc_kind_e  kind;
    logic [5:0]  rsvd;
    logic [7:0]  slot;
    logic [15:0] length;
    logic [31:0] offset;
  } pkt_desc_t;

  typedef struct packed {
    desc_kind_e  kind;
    logic [29:0] rsvd;
    logic [31:0] value;
  } msg_desc_t;

  // Same 64-bit word, kind picks the reading
  typedef union packed {
    pkt_desc_t pkt;
    msg_desc_t msg;
  } desc_u;

endpackage
